//--- hdl/mips_isa_pkg.sv
// MIPS32 subset encodings: opcode and funct values and instruction field widths
package mips_isa_pkg;

    parameter int XLEN       = 32;  // data and address width
    parameter int REG_ADDR_W = 5;   // register number
    parameter int SHAMT_W    = 5;
    parameter int OPCODE_W   = 6;   // funct has the same width

    // primary opcode, bits 31:26
    typedef enum logic [OPCODE_W-1:0] {
        OP_RTYPE = 6'h00,
        OP_J     = 6'h02,
        OP_BEQ   = 6'h04,
        OP_BNE   = 6'h05,
        OP_ADDIU = 6'h09,
        OP_ANDI  = 6'h0c,
        OP_ORI   = 6'h0d,
        OP_LUI   = 6'h0f,
        OP_LW    = 6'h23,
        OP_SW    = 6'h2b
    } opcode_e;

    // R-type function field, bits 5:0
    typedef enum logic [OPCODE_W-1:0] {
        F_SLL  = 6'h00,
        F_ADDU = 6'h21,
        F_SUBU = 6'h23,
        F_AND  = 6'h24,
        F_OR   = 6'h25,
        F_XOR  = 6'h26,
        F_SLT  = 6'h2a
    } funct_e;

endpackage

//--- hdl/mips_pipe_pkg.sv
// pipeline control, stage payload structs and ALU and forwarding codes
package mips_pipe_pkg;
    import mips_isa_pkg::*;

    // ALU_ADD is zero so a cleared payload is a harmless add
    typedef enum logic [2:0] {
        ALU_ADD = 3'd0,
        ALU_SUB = 3'd1,
        ALU_AND = 3'd2,
        ALU_OR  = 3'd3,
        ALU_XOR = 3'd4,
        ALU_SLT = 3'd5,
        ALU_SLL = 3'd6,
        ALU_LUI = 3'd7
    } alu_op_e;

    typedef enum logic [1:0] {
        FWD_REG = 2'd0,  // value read in decode
        FWD_MEM = 2'd1,  // ALU result in memory stage
        FWD_WB  = 2'd2   // final writeback value
    } fwd_sel_e;

    typedef struct packed {
        alu_op_e alu_op;
        logic    alu_src_imm;    // operand B is imm32
        logic    alu_src_shamt;  // operand A is shamt
        logic    reg_write;
        logic    mem_read;
        logic    mem_write;
        logic    is_branch;
        logic    branch_ne;      // bne rather than beq
        logic    is_jump;
        logic    uses_rs;
        logic    uses_rt;
        logic    dst_rd;         // rd rather than rt
    } ctrl_t;

    typedef struct packed {
        logic [XLEN-1:0] pc;
        logic [XLEN-1:0] instr;
    } ifid_t;

    typedef struct packed {
        logic [XLEN-1:0]       pc;
        ctrl_t                 ctrl;
        logic [REG_ADDR_W-1:0] rs;
        logic [REG_ADDR_W-1:0] rt;
        logic [REG_ADDR_W-1:0] dst;
        logic [XLEN-1:0]       rs_data;
        logic [XLEN-1:0]       rt_data;
        logic [XLEN-1:0]       imm32;
        logic [SHAMT_W-1:0]    shamt;
    } idex_t;

    typedef struct packed {
        logic [XLEN-1:0]       pc;
        ctrl_t                 ctrl;
        logic [REG_ADDR_W-1:0] dst;
        logic [XLEN-1:0]       alu_out;
        logic [XLEN-1:0]       store_data;
    } exmem_t;

    typedef struct packed {
        logic [XLEN-1:0]       pc;
        logic                  reg_write;
        logic                  mem_read;
        logic [REG_ADDR_W-1:0] dst;
        logic [XLEN-1:0]       alu_out;
        logic [XLEN-1:0]       load_data;
    } memwb_t;

endpackage

//--- hdl/hazard_if.sv
// hazard interface joining the pipeline to the stall and forwarding logic
`timescale 1ns/1ns

interface hazard_if import mips_isa_pkg::*, mips_pipe_pkg::*; ();

    logic [REG_ADDR_W-1:0] id_rs;
    logic [REG_ADDR_W-1:0] id_rt;
    logic                  id_uses_rs;
    logic                  id_uses_rt;
    logic [REG_ADDR_W-1:0] ex_rs;
    logic [REG_ADDR_W-1:0] ex_rt;
    logic                  ex_mem_read;
    logic [REG_ADDR_W-1:0] mem_dst;
    logic                  mem_reg_write;
    logic [REG_ADDR_W-1:0] wb_dst;
    logic                  wb_reg_write;
    logic                  stall;   // hold PC and IF/ID, bubble into ID/EX
    fwd_sel_e              fwd_a;
    fwd_sel_e              fwd_b;

    modport pipe (
        output id_rs, id_rt, id_uses_rs, id_uses_rt,
        output ex_rs, ex_rt, ex_mem_read,
        output mem_dst, mem_reg_write, wb_dst, wb_reg_write,
        input  stall, fwd_a, fwd_b
    );

    modport unit (
        input  id_rs, id_rt, id_uses_rs, id_uses_rt,
        input  ex_rs, ex_rt, ex_mem_read,
        input  mem_dst, mem_reg_write, wb_dst, wb_reg_write,
        output stall, fwd_a, fwd_b
    );

endinterface

//--- hdl/decoder.sv
// instruction decoder producing the control struct and extended immediate
`timescale 1ns/1ns

module decoder import mips_isa_pkg::*, mips_pipe_pkg::*; (
    input  logic [XLEN-1:0] instr_i,
    output ctrl_t           ctrl_o,
    output logic [XLEN-1:0] imm32_o
);

    opcode_e opcode;
    funct_e  funct;
    logic    imm_sext;
    logic    imm_jump;

    assign opcode = opcode_e'(instr_i[31:26]);
    assign funct  = funct_e'(instr_i[5:0]);

    always_comb begin
        ctrl_o   = '0;  // no-op unless recognised
        imm_sext = 1'b0;
        imm_jump = 1'b0;
        case (opcode)
            OP_RTYPE: begin
                ctrl_o.dst_rd    = 1'b1;
                ctrl_o.uses_rs   = 1'b1;
                ctrl_o.uses_rt   = 1'b1;
                ctrl_o.reg_write = (instr_i != '0);  // all-zero word stays a nop
                case (funct)
                    F_ADDU: ctrl_o.alu_op = ALU_ADD;
                    F_SUBU: ctrl_o.alu_op = ALU_SUB;
                    F_AND:  ctrl_o.alu_op = ALU_AND;
                    F_OR:   ctrl_o.alu_op = ALU_OR;
                    F_XOR:  ctrl_o.alu_op = ALU_XOR;
                    F_SLT:  ctrl_o.alu_op = ALU_SLT;
                    F_SLL: begin
                        ctrl_o.alu_op        = ALU_SLL;
                        ctrl_o.alu_src_shamt = 1'b1;
                        ctrl_o.uses_rs       = 1'b0;
                    end
                    default: ctrl_o = '0;  // unsupported funct
                endcase
            end
            OP_ADDIU, OP_ANDI, OP_ORI, OP_LUI: begin
                ctrl_o.alu_src_imm = 1'b1;
                ctrl_o.reg_write   = 1'b1;
                ctrl_o.uses_rs     = (opcode != OP_LUI);
                imm_sext           = (opcode == OP_ADDIU);
                ctrl_o.alu_op      = (opcode == OP_ANDI) ? ALU_AND :
                                     (opcode == OP_ORI)  ? ALU_OR  :
                                     (opcode == OP_LUI)  ? ALU_LUI : ALU_ADD;
            end
            OP_LW: begin
                ctrl_o.alu_src_imm = 1'b1;
                ctrl_o.reg_write   = 1'b1;
                ctrl_o.mem_read    = 1'b1;
                ctrl_o.uses_rs     = 1'b1;
                imm_sext           = 1'b1;
            end
            OP_SW: begin
                ctrl_o.alu_src_imm = 1'b1;
                ctrl_o.mem_write   = 1'b1;
                ctrl_o.uses_rs     = 1'b1;
                ctrl_o.uses_rt     = 1'b1;  // store data
                imm_sext           = 1'b1;
            end
            OP_BEQ, OP_BNE: begin
                ctrl_o.is_branch = 1'b1;
                ctrl_o.branch_ne = (opcode == OP_BNE);
                ctrl_o.uses_rs   = 1'b1;
                ctrl_o.uses_rt   = 1'b1;
                imm_sext         = 1'b1;
            end
            OP_J: begin
                ctrl_o.is_jump = 1'b1;
                imm_jump       = 1'b1;
            end
            default: ctrl_o = '0;
        endcase
    end

    // j carries its 26-bit index in imm32
    assign imm32_o = imm_jump ? {6'b0, instr_i[25:0]} :
                     imm_sext ? {{16{instr_i[15]}}, instr_i[15:0]} :
                                {16'b0, instr_i[15:0]};

endmodule

//--- hdl/reg_file.sv
// general purpose register file, two read ports and one write port
`timescale 1ns/1ns

module reg_file import mips_isa_pkg::*; (
    input  logic                  clk,
    input  logic                  rst_n_i,
    input  logic [REG_ADDR_W-1:0] rs_i,
    input  logic [REG_ADDR_W-1:0] rt_i,
    input  logic                  we_i,
    input  logic [REG_ADDR_W-1:0] waddr_i,
    input  logic [XLEN-1:0]       wdata_i,
    output logic [XLEN-1:0]       rs_data_o,
    output logic [XLEN-1:0]       rt_data_o
);

    logic [XLEN-1:0] regs [2**REG_ADDR_W];

    always_ff @(posedge clk or negedge rst_n_i) begin
        if (!rst_n_i) begin
            for (int i = 0; i < 2**REG_ADDR_W; i++) begin
                regs[i] <= '0;
            end
        end else if (we_i && waddr_i != '0) begin  // $zero is never written
            regs[waddr_i] <= wdata_i;
        end
    end

    // writeback in the same cycle bypasses the array
    assign rs_data_o = (rs_i == '0)                  ? '0      :
                       (we_i && waddr_i == rs_i)     ? wdata_i : regs[rs_i];
    assign rt_data_o = (rt_i == '0)                  ? '0      :
                       (we_i && waddr_i == rt_i)     ? wdata_i : regs[rt_i];

endmodule

//--- hdl/hazard_unit.sv
// load-use stall detection and execute-stage forwarding selection
`timescale 1ns/1ns

module hazard_unit import mips_isa_pkg::*, mips_pipe_pkg::*; (
    hazard_if.unit hz
);

    logic load_hit_rs;
    logic load_hit_rt;

    // newest producer wins, $zero never forwards
    function automatic fwd_sel_e pick_src(
        input logic [REG_ADDR_W-1:0] src,
        input logic                  mem_wr,
        input logic [REG_ADDR_W-1:0] mem_dst,
        input logic                  wb_wr,
        input logic [REG_ADDR_W-1:0] wb_dst
    );
        fwd_sel_e sel;
        sel = FWD_REG;
        if (src != '0 && mem_wr && mem_dst == src) begin
            sel = FWD_MEM;
        end else if (src != '0 && wb_wr && wb_dst == src) begin
            sel = FWD_WB;
        end
        return sel;
    endfunction

    assign load_hit_rs = hz.id_uses_rs && (hz.id_rs == hz.ex_rt);
    assign load_hit_rt = hz.id_uses_rt && (hz.id_rt == hz.ex_rt);

    // load data is only ready in writeback, so one bubble
    assign hz.stall = hz.ex_mem_read && (hz.ex_rt != '0) && (load_hit_rs || load_hit_rt);

    assign hz.fwd_a = pick_src(hz.ex_rs, hz.mem_reg_write, hz.mem_dst,
                               hz.wb_reg_write, hz.wb_dst);
    assign hz.fwd_b = pick_src(hz.ex_rt, hz.mem_reg_write, hz.mem_dst,
                               hz.wb_reg_write, hz.wb_dst);

endmodule

//--- hdl/stage_reg.sv
// pipeline register for any payload, with hold and flush to a bubble
`timescale 1ns/1ns

module stage_reg #(
    parameter type payload_t = logic
) (
    input  logic     clk,
    input  logic     rst_n_i,
    input  logic     hold_i,
    input  logic     flush_i,   // beats hold
    input  payload_t d_i,
    output payload_t q_o
);

    always_ff @(posedge clk or negedge rst_n_i) begin
        if (!rst_n_i) begin
            q_o <= '0;
        end else if (flush_i) begin
            q_o <= '0;  // zero payload means no writes
        end else if (!hold_i) begin
            q_o <= d_i;
        end
    end

endmodule

//--- hdl/alu.sv
// integer ALU with shift-amount selection on operand A
`timescale 1ns/1ns

module alu import mips_isa_pkg::*, mips_pipe_pkg::*; (
    input  logic [XLEN-1:0]    a_i,
    input  logic [XLEN-1:0]    b_i,
    input  logic [SHAMT_W-1:0] shamt_i,
    input  alu_op_e            alu_op_i,
    input  logic               alu_src_shamt_i,
    output logic [XLEN-1:0]    result_o
);

    logic [XLEN-1:0] op_a;

    assign op_a = alu_src_shamt_i ? {{(XLEN-SHAMT_W){1'b0}}, shamt_i} : a_i;

    always_comb begin
        case (alu_op_i)
            ALU_ADD: result_o = op_a + b_i;
            ALU_SUB: result_o = op_a - b_i;
            ALU_AND: result_o = op_a & b_i;
            ALU_OR:  result_o = op_a | b_i;
            ALU_XOR: result_o = op_a ^ b_i;
            ALU_SLT: result_o = {{(XLEN-1){1'b0}}, $signed(op_a) < $signed(b_i)};
            ALU_SLL: result_o = b_i << op_a[SHAMT_W-1:0];  // sll shifts rt
            ALU_LUI: result_o = {b_i[15:0], 16'b0};
            default: result_o = '0;
        endcase
    end

endmodule

//--- hdl/mips_core.sv
// five-stage MIPS32 integer pipeline with SRAM ports and writeback trace
`timescale 1ns/1ns

module mips_core import mips_isa_pkg::*, mips_pipe_pkg::*; #(
    parameter logic [XLEN-1:0] RESET_PC = 32'hbfc0_0000
) (
    input  logic                  clk,
    input  logic                  rst_n_i,
    input  logic [XLEN-1:0]       inst_rdata_i,
    input  logic [XLEN-1:0]       data_rdata_i,
    output logic                  inst_en_o,
    output logic [XLEN-1:0]       inst_addr_o,
    output logic                  data_en_o,
    output logic [3:0]            data_wen_o,
    output logic [XLEN-1:0]       data_addr_o,
    output logic [XLEN-1:0]       data_wdata_o,
    output logic [XLEN-1:0]       debug_wb_pc_o,
    output logic [3:0]            debug_wb_rf_wen_o,
    output logic [REG_ADDR_W-1:0] debug_wb_rf_wnum_o,
    output logic [XLEN-1:0]       debug_wb_rf_wdata_o
);

    logic                  run_q;      // set from the first edge after reset
    logic [XLEN-1:0]       pc_q;
    logic [XLEN-1:0]       pc_plus4;
    logic [XLEN-1:0]       pc_next;

    ifid_t                 ifid_d;
    ifid_t                 ifid_q;
    idex_t                 idex_d;
    idex_t                 idex_q;
    exmem_t                exmem_d;
    exmem_t                exmem_q;
    memwb_t                memwb_d;
    memwb_t                memwb_q;

    ctrl_t                 id_ctrl;
    logic [XLEN-1:0]       id_imm32;
    logic [REG_ADDR_W-1:0] id_rs;
    logic [REG_ADDR_W-1:0] id_rt;
    logic [REG_ADDR_W-1:0] id_rd;
    logic [XLEN-1:0]       id_rs_data;
    logic [XLEN-1:0]       id_rt_data;

    logic [XLEN-1:0]       ex_fwd_a;
    logic [XLEN-1:0]       ex_fwd_b;
    logic [XLEN-1:0]       ex_op_b;
    logic [XLEN-1:0]       ex_alu_out;
    logic [XLEN-1:0]       ex_pc_plus4;
    logic [XLEN-1:0]       ex_target;
    logic                  ex_taken;
    logic                  redirect;   // taken branch or jump in execute

    logic [XLEN-1:0]       wb_result;
    logic                  wb_wen;

    hazard_if hz ();

    function automatic logic [XLEN-1:0] fwd_pick(
        input fwd_sel_e        sel,
        input logic [XLEN-1:0] reg_val,
        input logic [XLEN-1:0] mem_val,
        input logic [XLEN-1:0] wb_val
    );
        case (sel)
            FWD_MEM: return mem_val;
            FWD_WB:  return wb_val;
            default: return reg_val;
        endcase
    endfunction

    always_ff @(posedge clk or negedge rst_n_i) begin
        if (!rst_n_i) begin
            run_q <= 1'b0;
            pc_q  <= RESET_PC;
        end else begin
            run_q <= 1'b1;
            pc_q  <= pc_next;
        end
    end

    assign pc_plus4 = pc_q + 32'd4;
    assign pc_next  = redirect              ? ex_target :
                      (!run_q || hz.stall)  ? pc_q      : pc_plus4;

    assign inst_en_o   = run_q && !hz.stall;
    assign inst_addr_o = pc_q;

    assign ifid_d = '{pc: pc_q, instr: inst_rdata_i};

    stage_reg #(.payload_t(ifid_t)) u_ifid (
        .clk     (clk),
        .rst_n_i (rst_n_i),
        .hold_i  (hz.stall),
        .flush_i (redirect || !run_q),  // nothing fetched before run_q
        .d_i     (ifid_d),
        .q_o     (ifid_q)
    );

    assign id_rs = ifid_q.instr[25:21];
    assign id_rt = ifid_q.instr[20:16];
    assign id_rd = ifid_q.instr[15:11];

    decoder u_decoder (
        .instr_i (ifid_q.instr),
        .ctrl_o  (id_ctrl),
        .imm32_o (id_imm32)
    );

    reg_file u_reg_file (
        .clk       (clk),
        .rst_n_i   (rst_n_i),
        .rs_i      (id_rs),
        .rt_i      (id_rt),
        .we_i      (memwb_q.reg_write),
        .waddr_i   (memwb_q.dst),
        .wdata_i   (wb_result),
        .rs_data_o (id_rs_data),
        .rt_data_o (id_rt_data)
    );

    assign hz.id_rs         = id_rs;
    assign hz.id_rt         = id_rt;
    assign hz.id_uses_rs    = id_ctrl.uses_rs;
    assign hz.id_uses_rt    = id_ctrl.uses_rt;
    assign hz.ex_rs         = idex_q.rs;
    assign hz.ex_rt         = idex_q.rt;
    assign hz.ex_mem_read   = idex_q.ctrl.mem_read;
    assign hz.mem_dst       = exmem_q.dst;
    assign hz.mem_reg_write = exmem_q.ctrl.reg_write;
    assign hz.wb_dst        = memwb_q.dst;
    assign hz.wb_reg_write  = memwb_q.reg_write;

    hazard_unit u_hazard (
        .hz (hz)
    );

    assign idex_d = '{
        pc:      ifid_q.pc,
        ctrl:    id_ctrl,
        rs:      id_rs,
        rt:      id_rt,
        dst:     id_ctrl.dst_rd ? id_rd : id_rt,
        rs_data: id_rs_data,
        rt_data: id_rt_data,
        imm32:   id_imm32,
        shamt:   ifid_q.instr[10:6]
    };

    stage_reg #(.payload_t(idex_t)) u_idex (
        .clk     (clk),
        .rst_n_i (rst_n_i),
        .hold_i  (1'b0),
        .flush_i (redirect || hz.stall),  // load-use inserts a bubble here
        .d_i     (idex_d),
        .q_o     (idex_q)
    );

    assign ex_fwd_a = fwd_pick(hz.fwd_a, idex_q.rs_data, exmem_q.alu_out, wb_result);
    assign ex_fwd_b = fwd_pick(hz.fwd_b, idex_q.rt_data, exmem_q.alu_out, wb_result);
    assign ex_op_b  = idex_q.ctrl.alu_src_imm ? idex_q.imm32 : ex_fwd_b;

    alu u_alu (
        .a_i             (ex_fwd_a),
        .b_i             (ex_op_b),
        .shamt_i         (idex_q.shamt),
        .alu_op_i        (idex_q.ctrl.alu_op),
        .alu_src_shamt_i (idex_q.ctrl.alu_src_shamt),
        .result_o        (ex_alu_out)
    );

    // no delay slot, both younger instructions are squashed
    assign ex_pc_plus4 = idex_q.pc + 32'd4;
    assign ex_taken    = idex_q.ctrl.is_branch &&
                         ((ex_fwd_a == ex_fwd_b) != idex_q.ctrl.branch_ne);
    assign redirect    = ex_taken || idex_q.ctrl.is_jump;
    assign ex_target   = idex_q.ctrl.is_jump ?
                         {ex_pc_plus4[31:28], idex_q.imm32[25:0], 2'b00} :
                         ex_pc_plus4 + {idex_q.imm32[29:0], 2'b00};

    assign exmem_d = '{
        pc:         idex_q.pc,
        ctrl:       idex_q.ctrl,
        dst:        idex_q.dst,
        alu_out:    ex_alu_out,
        store_data: ex_fwd_b
    };

    stage_reg #(.payload_t(exmem_t)) u_exmem (
        .clk     (clk),
        .rst_n_i (rst_n_i),
        .hold_i  (1'b0),
        .flush_i (1'b0),
        .d_i     (exmem_d),
        .q_o     (exmem_q)
    );

    assign data_en_o    = exmem_q.ctrl.mem_read || exmem_q.ctrl.mem_write;
    assign data_wen_o   = {4{exmem_q.ctrl.mem_write}};  // word stores only
    assign data_addr_o  = exmem_q.alu_out;
    assign data_wdata_o = exmem_q.store_data;

    assign memwb_d = '{
        pc:        exmem_q.pc,
        reg_write: exmem_q.ctrl.reg_write,
        mem_read:  exmem_q.ctrl.mem_read,
        dst:       exmem_q.dst,
        alu_out:   exmem_q.alu_out,
        load_data: data_rdata_i
    };

    stage_reg #(.payload_t(memwb_t)) u_memwb (
        .clk     (clk),
        .rst_n_i (rst_n_i),
        .hold_i  (1'b0),
        .flush_i (1'b0),
        .d_i     (memwb_d),
        .q_o     (memwb_q)
    );

    assign wb_result = memwb_q.mem_read ? memwb_q.load_data : memwb_q.alu_out;
    assign wb_wen    = memwb_q.reg_write && (memwb_q.dst != '0);  // hide $zero writes

    assign debug_wb_pc_o       = memwb_q.pc;
    assign debug_wb_rf_wen_o   = {4{wb_wen}};
    assign debug_wb_rf_wnum_o  = memwb_q.dst;
    assign debug_wb_rf_wdata_o = wb_result;

endmodule

//--- tests/tb_memory.sv
// instruction and data memory model with combinational reads and byte-lane writes
`timescale 1ns/1ns

module tb_memory (
    input  logic        clk,
    input  logic [31:0] inst_addr_i,
    output logic [31:0] inst_rdata_o,
    input  logic        data_en_i,
    input  logic [3:0]  data_wen_i,
    input  logic [31:0] data_addr_i,
    input  logic [31:0] data_wdata_i,
    output logic [31:0] data_rdata_o
);

    logic [31:0] imem [1024];  // loaded by the testbench
    logic [31:0] dmem [1024];

    // every word holds a value tied to its byte address
    initial begin
        for (int i = 0; i < 1024; i++) begin
            dmem[i] = (32'(i) << 2) ^ 32'h5a5a_a5a5;
        end
    end

    assign inst_rdata_o = imem[inst_addr_i[11:2]];
    assign data_rdata_o = data_en_i ? dmem[data_addr_i[11:2]] : 32'h0;

    always @(posedge clk) begin
        if (data_en_i) begin
            for (int b = 0; b < 4; b++) begin
                if (data_wen_i[b]) begin
                    dmem[data_addr_i[11:2]][8*b +: 8] <= data_wdata_i[8*b +: 8];
                end
            end
        end
    end

endmodule

//--- tests/tb_mips_core.sv
// testbench for the five-stage MIPS32 pipeline against an architectural model
`timescale 1ns/1ns

module tb_mips_core import mips_isa_pkg::*; ();

    localparam logic [31:0] RESET_PC = 32'h0000_0000;

    typedef struct packed {
        logic [31:0] pc;
        logic [4:0]  num;
        logic [31:0] data;
    } wb_rec_t;

    typedef struct packed {
        logic [31:0] addr;
        logic [31:0] data;
    } st_rec_t;

    logic        clk = 1'b0;
    logic        rst_n_i;
    logic [31:0] inst_rdata, data_rdata, inst_addr, data_addr, data_wdata;
    logic [31:0] wb_pc, wb_wdata;
    logic        inst_en, data_en;
    logic [3:0]  data_wen, wb_wen;
    logic [4:0]  wb_wnum;

    integer      seed = 32'h2fbac0ff;
    logic [31:0] prog [$];
    wb_rec_t     exp_wb [$];
    st_rec_t     exp_st [$];
    logic [31:0] loop_pc;
    logic        prog_ready = 1'b0;
    logic        fetch_seen = 1'b0;

    always #5 clk = ~clk;

    tb_memory u_mem (
        .clk(clk), .inst_addr_i(inst_addr), .inst_rdata_o(inst_rdata),
        .data_en_i(data_en), .data_wen_i(data_wen), .data_addr_i(data_addr),
        .data_wdata_i(data_wdata), .data_rdata_o(data_rdata)
    );

    mips_core #(.RESET_PC(RESET_PC)) DUT (
        .clk(clk), .rst_n_i(rst_n_i), .inst_rdata_i(inst_rdata), .data_rdata_i(data_rdata),
        .inst_en_o(inst_en), .inst_addr_o(inst_addr), .data_en_o(data_en),
        .data_wen_o(data_wen), .data_addr_o(data_addr), .data_wdata_o(data_wdata),
        .debug_wb_pc_o(wb_pc), .debug_wb_rf_wen_o(wb_wen), .debug_wb_rf_wnum_o(wb_wnum),
        .debug_wb_rf_wdata_o(wb_wdata)
    );

    task automatic fail_run(input string msg);
        $display("%s", msg);
        $display("Test failed");
        $fatal(1);
    endtask

    task automatic check_hex(input string name, input logic [31:0] exp, input logic [31:0] act);
        assert (exp === act)
            else fail_run($sformatf("Error: %s expected %h got %h", name, exp, act));
    endtask

    function automatic logic [31:0] r_type(input funct_e f, input logic [4:0] rs,
                                           input logic [4:0] rt, input logic [4:0] rd,
                                           input logic [4:0] sh);
        return {OP_RTYPE, rs, rt, rd, sh, f};
    endfunction

    function automatic logic [31:0] i_type(input opcode_e op, input logic [4:0] rs,
                                           input logic [4:0] rt, input logic [15:0] imm);
        return {op, rs, rt, imm};
    endfunction

    function automatic logic [31:0] j_type(input logic [31:0] target);
        return {OP_J, target[27:2]};
    endfunction

    function automatic logic [4:0] rand_reg();
        return 5'(1 + ($unsigned($random(seed)) % 8));  // sources r1..r8
    endfunction

    function automatic logic [15:0] rand_imm();
        return 16'($random(seed));
    endfunction

    function automatic logic [31:0] next_pc();
        return RESET_PC + 32'(prog.size() * 4);
    endfunction

    task automatic build_program();
        funct_e alu_f [6];
        alu_f = '{F_ADDU, F_SUBU, F_AND, F_OR, F_XOR, F_SLT};
        for (int r = 1; r <= 8; r++) begin  // lui then ori form a distance-one chain
            prog.push_back(i_type(OP_LUI, 5'd0, 5'(r), rand_imm()));
            prog.push_back(i_type(OP_ORI, 5'(r), 5'(r), rand_imm()));
        end
        for (int k = 0; k < 6; k++) begin
            prog.push_back(r_type(alu_f[k], rand_reg(), rand_reg(), 5'(9 + k), 5'd0));
        end
        prog.push_back(r_type(F_SLL, 5'd0, rand_reg(), 5'd15, 5'(rand_imm())));
        prog.push_back(i_type(OP_ADDIU, rand_reg(), 5'd9, rand_imm()));
        prog.push_back(i_type(OP_ANDI, rand_reg(), 5'd10, rand_imm()));
        prog.push_back(i_type(OP_ORI, rand_reg(), 5'd11, rand_imm()));
        prog.push_back(i_type(OP_LUI, 5'd0, 5'd12, rand_imm()));
        prog.push_back(r_type(F_ADDU, 5'd1, 5'd2, 5'd0, 5'd0));  // hidden $zero write
        for (int d = 1; d <= 3; d++) begin  // consumer at distance d
            prog.push_back(r_type(F_ADDU, rand_reg(), rand_reg(), 5'd16, 5'd0));
            for (int f = 1; f < d; f++) begin
                prog.push_back(i_type(OP_ORI, rand_reg(), 5'd17, rand_imm()));
            end
            prog.push_back(r_type(F_XOR, 5'd16, rand_reg(), 5'd18, 5'd0));
            prog.push_back(r_type(F_SUBU, 5'd18, 5'd16, 5'd19, 5'd0));
        end
        prog.push_back(i_type(OP_ORI, 5'd0, 5'd20, rand_imm() & 16'h07f0));
        prog.push_back(i_type(OP_SW, 5'd20, rand_reg(), 16'd4));
        prog.push_back(i_type(OP_LW, 5'd20, 5'd21, 16'd4));
        prog.push_back(r_type(F_ADDU, 5'd21, 5'd21, 5'd22, 5'd0));  // load-use
        prog.push_back(i_type(OP_LW, 5'd20, 5'd23, 16'd8));  // untouched word
        prog.push_back(r_type(F_SUBU, 5'd2, 5'd23, 5'd24, 5'd0));
        prog.push_back(i_type(OP_SW, 5'd20, 5'd24, 16'd12));
        prog.push_back(r_type(F_ADDU, 5'd3, 5'd3, 5'd25, 5'd0));
        prog.push_back(i_type(OP_LW, 5'd20, 5'd26, 16'd12));
        prog.push_back(i_type(OP_BEQ, 5'd1, 5'd1, 16'd1));  // taken
        prog.push_back(i_type(OP_ADDIU, 5'd0, 5'd27, 16'h1111));
        prog.push_back(i_type(OP_BNE, 5'd1, 5'd1, 16'd1));  // not taken
        prog.push_back(i_type(OP_ADDIU, 5'd0, 5'd27, 16'h2222));
        prog.push_back(i_type(OP_BNE, 5'd27, 5'd0, 16'd1));  // taken since r27 holds 0x2222
        prog.push_back(i_type(OP_ADDIU, 5'd0, 5'd28, 16'h3333));
        prog.push_back(i_type(OP_BEQ, 5'd27, 5'd0, 16'd1));  // not taken
        prog.push_back(i_type(OP_ADDIU, 5'd0, 5'd29, 16'h4444));
        prog.push_back(r_type(F_ADDU, 5'd5, 5'd0, 5'd30, 5'd0));
        prog.push_back(i_type(OP_BEQ, 5'd30, 5'd5, 16'd1));  // forwarded compare
        prog.push_back(i_type(OP_ADDIU, 5'd0, 5'd31, 16'h5555));
        prog.push_back(j_type(next_pc() + 32'd8));
        prog.push_back(i_type(OP_ADDIU, 5'd0, 5'd31, 16'h6666));
        loop_pc = next_pc();
        prog.push_back(j_type(loop_pc));
    endtask

    task automatic run_model();
        logic [31:0] gr [32];
        logic [31:0] gmem [logic [31:0]];
        logic [31:0] pc, npc, ins, simm, zimm, a, b, res, addr;
        logic        wr;
        logic [4:0]  dst;
        for (int r = 0; r < 32; r++) begin
            gr[r] = 32'h0;
        end
        pc = RESET_PC;
        while (pc != loop_pc) begin
            ins  = prog[(pc - RESET_PC) >> 2];
            a    = gr[ins[25:21]];
            b    = gr[ins[20:16]];
            simm = {{16{ins[15]}}, ins[15:0]};
            zimm = {16'h0, ins[15:0]};
            npc  = pc + 32'd4;
            wr   = 1'b1;
            dst  = ins[20:16];
            res  = 32'h0;
            case (opcode_e'(ins[31:26]))
                OP_RTYPE: begin
                    dst = ins[15:11];
                    case (funct_e'(ins[5:0]))
                        F_ADDU:  res = a + b;
                        F_SUBU:  res = a - b;
                        F_AND:   res = a & b;
                        F_OR:    res = a | b;
                        F_XOR:   res = a ^ b;
                        F_SLT:   res = {31'h0, $signed(a) < $signed(b)};
                        default: res = b << ins[10:6];
                    endcase
                end
                OP_ADDIU: res = a + simm;
                OP_ANDI:  res = a & zimm;
                OP_ORI:   res = a | zimm;
                OP_LUI:   res = {ins[15:0], 16'h0};
                OP_LW: begin
                    addr = a + simm;
                    res  = gmem.exists(addr) ? gmem[addr] : (addr ^ 32'h5a5a_a5a5);
                end
                OP_SW: begin
                    wr = 1'b0;
                    gmem[a + simm] = b;
                    exp_st.push_back('{addr: a + simm, data: b});
                end
                OP_BEQ, OP_BNE: begin
                    wr = 1'b0;
                    if ((a == b) == (ins[31:26] == 6'h04)) begin
                        npc = npc + (simm << 2);
                    end
                end
                default: begin
                    wr  = 1'b0;
                    npc = {npc[31:28], ins[25:0], 2'b00};
                end
            endcase
            if (wr && dst != 5'd0) begin
                gr[dst] = res;
                exp_wb.push_back('{pc: pc, num: dst, data: res});
            end
            pc = npc;
        end
    endtask

    always @(negedge clk) begin : trace_check
        wb_rec_t w;
        st_rec_t s;
        if (!rst_n_i) begin
            assert (!inst_en && !data_en && data_wen == 4'h0 && wb_wen == 4'h0)
                else fail_run("memory or trace enable active during reset");
        end else begin
            if (inst_en && !fetch_seen) begin
                fetch_seen = 1'b1;
                check_hex("inst_addr_o", RESET_PC, inst_addr);
            end
            if (wb_wen != 4'h0) begin
                assert (exp_wb.size() > 0)
                    else fail_run("register writeback seen after the expected trace ended");
                w = exp_wb.pop_front();
                check_hex("debug_wb_rf_wen_o", 32'hf, 32'(wb_wen));
                check_hex("debug_wb_pc_o", w.pc, wb_pc);
                check_hex("debug_wb_rf_wnum_o", 32'(w.num), 32'(wb_wnum));
                check_hex("debug_wb_rf_wdata_o", w.data, wb_wdata);
            end
            if (data_wen != 4'h0) begin
                assert (exp_st.size() > 0)
                    else fail_run("store seen that the program never makes");
                s = exp_st.pop_front();
                check_hex("data_wen_o", 32'hf, 32'(data_wen));
                check_hex("data_addr_o", s.addr, data_addr);
                check_hex("data_wdata_o", s.data, data_wdata);
            end
        end
    end

    initial begin : watchdog
        wait (prog_ready);
        repeat (prog.size() * 4 + 50) @(posedge clk);
        fail_run("timeout, the core never reached the final loop");
    end

    initial begin
        rst_n_i = 1'b0;
        for (int i = 0; i < 1024; i++) begin
            u_mem.imem[i] = 32'h0;  // nops past the program
        end
        build_program();
        for (int i = 0; i < prog.size(); i++) begin
            u_mem.imem[i] = prog[i];
        end
        run_model();
        prog_ready = 1'b1;
        repeat (2) @(negedge clk);
        rst_n_i = 1'b1;
        while (!(inst_en && inst_addr == loop_pc)) @(negedge clk);
        repeat (8) @(negedge clk);  // drain the pipeline
        if (exp_wb.size() == 0 && exp_st.size() == 0) begin
            $display("Test completed successfully");
            $finish;
        end else begin
            fail_run($sformatf("%0d writebacks and %0d stores never retired",
                               exp_wb.size(), exp_st.size()));
        end
    end

endmodule

//--- mips_core.f
hdl/mips_isa_pkg.sv
hdl/mips_pipe_pkg.sv
hdl/hazard_if.sv
hdl/decoder.sv
hdl/reg_file.sv
hdl/hazard_unit.sv
hdl/stage_reg.sv
hdl/alu.sv
hdl/mips_core.sv
tests/tb_memory.sv
tests/tb_mips_core.sv

//--- run_sim.sh
#!/usr/bin/env bash
# Build and run the mips_core testbench with Verilator.
set -e

cd "$(dirname "$0")"

rm -rf obj_dir sim.log

verilator --binary --timing -f mips_core.f --top-module tb_mips_core -o vtb_mips_core

./obj_dir/vtb_mips_core | tee sim.log

if grep -q "Test completed successfully" sim.log; then
    exit 0
else
    exit 1
fi
